// File: rtl/dram_sched_pkg.sv
package dram_sched_pkg;

	// address map, msb to lsb: row | bank | col
	localparam int BANK_BITS = 2;                               // bank select
	localparam int ROW_BITS  = 8;                               // row within a bank
	localparam int COL_BITS  = 6;                               // column within a row
	localparam int ADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS; // flat request address, 16 bits

	localparam int NUM_BANKS = 2 ** BANK_BITS; // four banks

	// field offsets inside a flat address
	// the column sits at bit 0 and needs no offset of its own
	localparam int BANK_LSB = COL_BITS;             // bank right above the column
	localparam int ROW_LSB  = BANK_LSB + BANK_BITS; // row takes the upper bits

	// request kind as it enters the queue
	typedef enum logic {
		REQ_READ  = 1'b0, // becomes CMD_RD
		REQ_WRITE = 1'b1  // becomes CMD_WR
	} req_op_t;

	// commands on the dram side
	// one of these leaves the scheduler per cmd_valid pulse
	typedef enum logic [2:0] {
		CMD_PRE = 3'd0, // close the open row of one bank
		CMD_ACT = 3'd1, // open a row in a closed bank
		CMD_RD  = 3'd2, // column read on the open row
		CMD_WR  = 3'd3, // column write on the open row
		CMD_REF = 3'd4  // all-bank refresh, every bank must be closed
	} cmd_op_t;

	// timing values are not here
	// they are parameters of dram_sched and are handed down from there

endpackage

// File: rtl/request_queue.sv
`timescale 1ns/1ps

module request_queue import dram_sched_pkg::*; #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 push,       // single-cycle request strobe
	input  req_op_t              push_op,
	input  logic [ADDR_BITS-1:0] push_addr,
	input  logic                 pop,        // head has been issued as RD or WR
	output logic                 head_valid, // queue not empty
	output req_op_t              head_op,
	output logic [ADDR_BITS-1:0] head_addr,
	output logic                 full
);

	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1); // must hold QUEUE_DEPTH itself

	req_op_t              op_mem   [QUEUE_DEPTH];
	logic [ADDR_BITS-1:0] addr_mem [QUEUE_DEPTH];
	logic [PTR_BITS-1:0]  wr_ptr;
	logic [PTR_BITS-1:0]  rd_ptr;
	logic [CNT_BITS-1:0]  count;  // occupancy
	logic                 do_push;
	logic                 do_pop;

	assign do_push = push && !full; // a strobe while full is dropped
	assign do_pop  = pop && head_valid;

	// pointers wrap at QUEUE_DEPTH, which need not be a power of two
	function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)  rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle, or push and pop together
			endcase
		end
	end

	// storage, written only on an accepted push
	always_ff @(posedge clk) begin
		if (do_push) begin
			op_mem[wr_ptr]   <= push_op;
			addr_mem[wr_ptr] <= push_addr;
		end
	end

	assign head_valid = (count != '0);                     // visible the cycle after a push
	assign full       = (count == CNT_BITS'(QUEUE_DEPTH));
	assign head_op    = op_mem[rd_ptr];
	assign head_addr  = addr_mem[rd_ptr];

endmodule

// File: rtl/bank_tracker.sv
`timescale 1ns/1ps

module bank_tracker import dram_sched_pkg::*; #(
	parameter int T_RCD = 4,
	parameter int T_RP  = 4,
	parameter int T_RAS = 10,
	parameter int T_CCD = 2,
	parameter int T_RRD = 3
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               iss_valid, // command leaving the scheduler
	input  cmd_op_t                            iss_op,
	input  logic [BANK_BITS-1:0]               iss_bank,
	input  logic [ROW_BITS-1:0]                iss_row,
	output logic [NUM_BANKS-1:0]               bank_open,
	output logic [NUM_BANKS-1:0][ROW_BITS-1:0] open_row,
	output logic [NUM_BANKS-1:0]               act_ok,    // tRP met
	output logic [NUM_BANKS-1:0]               pre_ok,    // tRAS met
	output logic [NUM_BANKS-1:0]               rw_ok,     // tRCD met
	output logic                               act_gap_ok, // tRRD met since last ACT
	output logic                               rw_gap_ok   // tCCD met since last RD/WR
);

	// loads are two short of the rule
	// one cycle goes to this update, one to the registered decision in the sequencer
	localparam int RCD_LOAD = (T_RCD > 2) ? T_RCD - 2 : 0;
	localparam int RP_LOAD  = (T_RP > 2)  ? T_RP - 2  : 0;
	localparam int RAS_LOAD = (T_RAS > 2) ? T_RAS - 2 : 0;
	localparam int CCD_MIN  = (T_CCD > 2) ? T_CCD - 2 : 0;
	localparam int RRD_MIN  = (T_RRD > 2) ? T_RRD - 2 : 0;

	localparam int BANK_MAX_A = (T_RCD > T_RP) ? T_RCD : T_RP;
	localparam int BANK_MAX   = (BANK_MAX_A > T_RAS) ? BANK_MAX_A : T_RAS;
	localparam int CNT_BITS   = $clog2(BANK_MAX + 1);
	localparam int GAP_MAX    = (T_CCD > T_RRD) ? T_CCD : T_RRD;
	localparam int GAP_BITS   = $clog2(GAP_MAX + 1);

	logic                iss_act;
	logic                iss_pre;
	logic                iss_rw;
	logic                iss_ref;
	logic [GAP_BITS-1:0] act_since; // saturating, cycles since last ACT
	logic [GAP_BITS-1:0] rw_since;  // saturating, cycles since last RD/WR

	assign iss_act = iss_valid && (iss_op == CMD_ACT);
	assign iss_pre = iss_valid && (iss_op == CMD_PRE);
	assign iss_rw  = iss_valid && (iss_op == CMD_RD || iss_op == CMD_WR);
	assign iss_ref = iss_valid && (iss_op == CMD_REF);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		logic                hit;    // this bank is the command's target
		logic                open_q;
		logic [ROW_BITS-1:0] row_q;
		logic [CNT_BITS-1:0] rcd_cnt;
		logic [CNT_BITS-1:0] rp_cnt;
		logic [CNT_BITS-1:0] ras_cnt;

		assign hit = (iss_bank == BANK_BITS'(b));

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				open_q  <= 1'b0;
				rcd_cnt <= '0; // zero means the rule is already met
				rp_cnt  <= '0;
				ras_cnt <= '0;
			end else begin
				if (rcd_cnt != '0) rcd_cnt <= rcd_cnt - 1'b1;
				if (rp_cnt != '0)  rp_cnt  <= rp_cnt - 1'b1;
				if (ras_cnt != '0) ras_cnt <= ras_cnt - 1'b1;
				if (iss_act && hit) begin
					open_q  <= 1'b1;
					rcd_cnt <= CNT_BITS'(RCD_LOAD);
					ras_cnt <= CNT_BITS'(RAS_LOAD);
				end
				if (iss_pre && hit) begin
					open_q <= 1'b0;
					rp_cnt <= CNT_BITS'(RP_LOAD);
				end
				if (iss_ref) open_q <= 1'b0; // refresh leaves every bank closed
			end
		end

		// row is only meaningful while open_q is set
		always_ff @(posedge clk) begin
			if (iss_act && hit) row_q <= iss_row;
		end

		assign bank_open[b] = open_q;
		assign open_row[b]  = row_q;
		assign act_ok[b]    = (rp_cnt == '0);
		assign pre_ok[b]    = (ras_cnt == '0);
		assign rw_ok[b]     = (rcd_cnt == '0);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			act_since <= '1; // saturated, nothing to wait for after reset
			rw_since  <= '1;
		end else begin
			if (iss_act)              act_since <= '0;
			else if (act_since != '1) act_since <= act_since + 1'b1;
			if (iss_rw)               rw_since  <= '0;
			else if (rw_since != '1)  rw_since  <= rw_since + 1'b1;
		end
	end

	assign act_gap_ok = (act_since >= GAP_BITS'(RRD_MIN));
	assign rw_gap_ok  = (rw_since >= GAP_BITS'(CCD_MIN));

endmodule

// File: rtl/refresh_timer.sv
`timescale 1ns/1ps

module refresh_timer import dram_sched_pkg::*; #(
	parameter int T_REFI = 400,
	parameter int T_RFC  = 20
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    iss_valid,
	input  cmd_op_t iss_op,
	output logic    refresh_due,  // REF owed, sequencer drains banks
	output logic    refresh_busy  // tRFC blackout after REF
);

	localparam int REFI_BITS = $clog2(T_REFI + 1);
	localparam int RFC_BITS  = $clog2(T_RFC + 1);
	localparam int RFC_LOAD  = (T_RFC > 2) ? T_RFC - 2 : 0; // decision register eats one cycle

	logic                 iss_ref;
	logic [REFI_BITS-1:0] refi_cnt; // counts up to the interval, then holds
	logic [RFC_BITS-1:0]  rfc_cnt;

	assign iss_ref = iss_valid && (iss_op == CMD_REF);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt    <= '0;
			refresh_due <= 1'b0;
			rfc_cnt     <= '0;
		end else if (iss_ref) begin
			refi_cnt    <= '0;                  // next interval starts at the REF
			refresh_due <= 1'b0;
			rfc_cnt     <= RFC_BITS'(RFC_LOAD);
		end else begin
			if (rfc_cnt != '0) rfc_cnt <= rfc_cnt - 1'b1;
			if (!refresh_due) begin
				if (refi_cnt == REFI_BITS'(T_REFI - 1)) refresh_due <= 1'b1;
				else refi_cnt <= refi_cnt + 1'b1;
			end
		end
	end

	assign refresh_busy = (rfc_cnt != '0);

endmodule

// File: rtl/command_sequencer.sv
`timescale 1ns/1ps

module command_sequencer import dram_sched_pkg::*; (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               head_valid,
	input  req_op_t                            head_op,
	input  logic [ADDR_BITS-1:0]               head_addr,
	input  logic [NUM_BANKS-1:0]               bank_open,
	input  logic [NUM_BANKS-1:0][ROW_BITS-1:0] open_row,
	input  logic [NUM_BANKS-1:0]               act_ok,
	input  logic [NUM_BANKS-1:0]               pre_ok,
	input  logic [NUM_BANKS-1:0]               rw_ok,
	input  logic                               act_gap_ok,
	input  logic                               rw_gap_ok,
	input  logic                               refresh_due,
	input  logic                               refresh_busy,
	output logic                               pop,       // head leaves with this RD/WR decision
	output logic                               cmd_valid,
	output cmd_op_t                            cmd_op,
	output logic [BANK_BITS-1:0]               cmd_bank,
	output logic [ROW_BITS-1:0]                cmd_row,
	output logic [COL_BITS-1:0]                cmd_col
);

	logic [ROW_BITS-1:0]  hd_row;
	logic [BANK_BITS-1:0] hd_bank;
	logic [COL_BITS-1:0]  hd_col;
	logic                 pre_found; // some open bank may be closed now
	logic [BANK_BITS-1:0] pre_bank;
	logic                 nxt_valid;
	cmd_op_t              nxt_op;
	logic [BANK_BITS-1:0] nxt_bank;
	logic [ROW_BITS-1:0]  nxt_row;
	logic [COL_BITS-1:0]  nxt_col;

	// split the head address
	assign hd_row  = head_addr[ROW_LSB +: ROW_BITS];
	assign hd_bank = head_addr[BANK_LSB +: BANK_BITS];
	assign hd_col  = head_addr[COL_BITS-1:0];

	always_comb begin
		nxt_valid = 1'b0;
		nxt_op    = CMD_REF;
		nxt_bank  = hd_bank;
		nxt_row   = hd_row;
		nxt_col   = hd_col;
		pre_found = 1'b0;
		pre_bank  = '0;
		// scan from the top so the lowest index wins
		for (int b = NUM_BANKS - 1; b >= 0; b--) begin
			if (bank_open[b] && pre_ok[b]) begin
				pre_found = 1'b1;
				pre_bank  = BANK_BITS'(b);
			end
		end
		if (cmd_valid || refresh_busy) begin
			// tracker has not seen the last command yet, or tRFC blackout
		end else if (refresh_due) begin
			if (pre_found) begin
				nxt_valid = 1'b1; // drain open banks one per cycle
				nxt_op    = CMD_PRE;
				nxt_bank  = pre_bank;
			end else if (bank_open == '0 && &act_ok) begin
				nxt_valid = 1'b1; // all closed and precharged
				nxt_op    = CMD_REF;
				nxt_bank  = '0;
				nxt_row   = '0;
				nxt_col   = '0;
			end
		end else if (head_valid) begin
			if (!bank_open[hd_bank]) begin
				nxt_valid = act_ok[hd_bank] && act_gap_ok;
				nxt_op    = CMD_ACT;
			end else if (open_row[hd_bank] == hd_row) begin
				nxt_valid = rw_ok[hd_bank] && rw_gap_ok; // row hit
				nxt_op    = (head_op == REQ_WRITE) ? CMD_WR : CMD_RD;
			end else begin
				nxt_valid = pre_ok[hd_bank]; // conflict, close the old row first
				nxt_op    = CMD_PRE;
			end
		end
	end

	assign pop = nxt_valid && (nxt_op == CMD_RD || nxt_op == CMD_WR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) cmd_valid <= 1'b0;
		else cmd_valid <= nxt_valid;
	end

	// command fields, qualified by cmd_valid
	always_ff @(posedge clk) begin
		cmd_op   <= nxt_op;
		cmd_bank <= nxt_bank;
		cmd_row  <= nxt_row;
		cmd_col  <= nxt_col;
	end

endmodule

// File: rtl/dram_sched.sv
`timescale 1ns/1ps

module dram_sched import dram_sched_pkg::*; #(
	parameter int QUEUE_DEPTH = 8,
	parameter int T_RCD       = 4,
	parameter int T_RP        = 4,
	parameter int T_RAS       = 10,
	parameter int T_CCD       = 2,
	parameter int T_RRD       = 3,
	parameter int T_REFI      = 400,
	parameter int T_RFC       = 20
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req_valid, // strobe, dropped while full
	input  req_op_t              req_op,
	input  logic [ADDR_BITS-1:0] req_addr,
	output logic                 full,
	output logic                 cmd_valid, // one command per pulse
	output cmd_op_t              cmd_op,
	output logic [BANK_BITS-1:0] cmd_bank,
	output logic [ROW_BITS-1:0]  cmd_row,
	output logic [COL_BITS-1:0]  cmd_col
);

	logic                               head_valid;
	req_op_t                            head_op;
	logic [ADDR_BITS-1:0]               head_addr;
	logic                               pop;
	logic [NUM_BANKS-1:0]               bank_open;
	logic [NUM_BANKS-1:0][ROW_BITS-1:0] open_row;
	logic [NUM_BANKS-1:0]               act_ok;
	logic [NUM_BANKS-1:0]               pre_ok;
	logic [NUM_BANKS-1:0]               rw_ok;
	logic                               act_gap_ok;
	logic                               rw_gap_ok;
	logic                               refresh_due;
	logic                               refresh_busy;

	request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
		.clk, .rst_n,
		.push(req_valid), .push_op(req_op), .push_addr(req_addr),
		.pop, .head_valid, .head_op, .head_addr, .full
	);

	// issued command is fed back from the sequencer outputs
	bank_tracker #(
		.T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_CCD(T_CCD), .T_RRD(T_RRD)
	) i_tracker (
		.clk, .rst_n,
		.iss_valid(cmd_valid), .iss_op(cmd_op), .iss_bank(cmd_bank), .iss_row(cmd_row),
		.bank_open, .open_row, .act_ok, .pre_ok, .rw_ok, .act_gap_ok, .rw_gap_ok
	);

	refresh_timer #(.T_REFI(T_REFI), .T_RFC(T_RFC)) i_refresh (
		.clk, .rst_n,
		.iss_valid(cmd_valid), .iss_op(cmd_op),
		.refresh_due, .refresh_busy
	);

	command_sequencer i_seq (
		.clk, .rst_n,
		.head_valid, .head_op, .head_addr,
		.bank_open, .open_row, .act_ok, .pre_ok, .rw_ok, .act_gap_ok, .rw_gap_ok,
		.refresh_due, .refresh_busy,
		.pop, .cmd_valid, .cmd_op, .cmd_bank, .cmd_row, .cmd_col
	);

endmodule

// File: test/dram_sched_asserts.sv
`timescale 1ns/1ps

module dram_sched_asserts import dram_sched_pkg::*; #(
	parameter int T_RCD = 4,
	parameter int T_RP  = 4,
	parameter int T_RAS = 10,
	parameter int T_CCD = 2,
	parameter int T_RRD = 3,
	parameter int T_RFC = 20
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 cmd_valid,
	input cmd_op_t              cmd_op,
	input logic [BANK_BITS-1:0] cmd_bank
);

	// gap counters hold the cycles since the event, saturated at all ones
	logic [15:0]          since_act [NUM_BANKS]; // per bank, last ACT
	logic [15:0]          since_pre [NUM_BANKS]; // per bank, last PRE
	logic [15:0]          since_any_act;
	logic [15:0]          since_rw;
	logic [15:0]          since_ref;
	logic [NUM_BANKS-1:0] open_model;            // banks open as seen at the ports
	logic                 is_act;
	logic                 is_pre;
	logic                 is_rw;
	logic                 is_ref;
	int                   fail_count = 0;        // read by the testbench at the end

	assign is_act = cmd_valid && (cmd_op == CMD_ACT);
	assign is_pre = cmd_valid && (cmd_op == CMD_PRE);
	assign is_rw  = cmd_valid && (cmd_op == CMD_RD || cmd_op == CMD_WR);
	assign is_ref = cmd_valid && (cmd_op == CMD_REF);

	function automatic logic [15:0] count_up_sat(input logic [15:0] v);
		return (v == '1) ? v : v + 16'd1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				since_act[b] <= '1;
				since_pre[b] <= '1;
			end
			since_any_act <= '1;
			since_rw      <= '1;
			since_ref     <= '1;
			open_model    <= '0;
		end else begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (is_act && cmd_bank == BANK_BITS'(b)) since_act[b] <= 16'd1;
				else since_act[b] <= count_up_sat(since_act[b]);
				if (is_pre && cmd_bank == BANK_BITS'(b)) since_pre[b] <= 16'd1;
				else since_pre[b] <= count_up_sat(since_pre[b]);
			end
			since_any_act <= is_act ? 16'd1 : count_up_sat(since_any_act);
			since_rw      <= is_rw ? 16'd1 : count_up_sat(since_rw);
			since_ref     <= is_ref ? 16'd1 : count_up_sat(since_ref);
			if (is_act) open_model[cmd_bank] <= 1'b1;
			if (is_pre) open_model[cmd_bank] <= 1'b0;
			if (is_ref) open_model <= '0; // refresh closes everything
		end
	end

	a_rcd: assert property (@(posedge clk) disable iff (!rst_n)
		is_rw |-> since_act[cmd_bank] >= 16'(T_RCD))
		else begin
			$error("RD/WR on bank %0d came sooner than tRCD after its ACT", cmd_bank);
			fail_count++;
		end

	a_rp: assert property (@(posedge clk) disable iff (!rst_n)
		is_act |-> since_pre[cmd_bank] >= 16'(T_RP))
		else begin
			$error("ACT on bank %0d came sooner than tRP after its PRE", cmd_bank);
			fail_count++;
		end

	a_ras: assert property (@(posedge clk) disable iff (!rst_n)
		is_pre |-> since_act[cmd_bank] >= 16'(T_RAS))
		else begin
			$error("PRE on bank %0d came sooner than tRAS after its ACT", cmd_bank);
			fail_count++;
		end

	a_ccd: assert property (@(posedge clk) disable iff (!rst_n)
		is_rw |-> since_rw >= 16'(T_CCD))
		else begin
			$error("two column commands closer than tCCD");
			fail_count++;
		end

	a_rrd: assert property (@(posedge clk) disable iff (!rst_n)
		is_act |-> since_any_act >= 16'(T_RRD))
		else begin
			$error("two ACT commands closer than tRRD");
			fail_count++;
		end

	// blackout covers every command, another REF too
	a_rfc: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |-> since_ref >= 16'(T_RFC))
		else begin
			$error("command issued inside the tRFC blackout");
			fail_count++;
		end

	a_ref_closed: assert property (@(posedge clk) disable iff (!rst_n)
		is_ref |-> open_model == '0)
		else begin
			$error("REF issued while a bank was still open");
			fail_count++;
		end

endmodule

// File: test/dram_sched_tb.sv
`timescale 1ns/1ps

module dram_sched_tb import dram_sched_pkg::*; ();

	localparam int QUEUE_DEPTH = 4;
	localparam int T_RCD       = 4;
	localparam int T_RP        = 4;
	localparam int T_RAS       = 10;
	localparam int T_CCD       = 3;                            // above the 2-cycle command spacing
	localparam int T_RRD       = 7;                            // longer than ACT, RD/WR, ACT in order
	localparam int T_REFI      = 400;
	localparam int T_RFC       = 20;
	localparam int N_RAND      = 120;                          // random requests in the main test
	localparam int TOTAL_REQ   = N_RAND + QUEUE_DEPTH + 2;
	localparam int WATCHDOG_CYCLES = TOTAL_REQ * (T_RCD + T_RP + T_RAS + T_RFC) + T_REFI;
	localparam int REF_WAIT    = 2 * T_REFI + 2 * T_RFC;       // run past two refresh intervals

	logic                 clk;
	logic                 rst_n;
	logic                 req_valid;
	req_op_t              req_op;
	logic [ADDR_BITS-1:0] req_addr;
	logic                 full;
	logic                 cmd_valid;
	cmd_op_t              cmd_op;
	logic [BANK_BITS-1:0] cmd_bank;
	logic [ROW_BITS-1:0]  cmd_row;
	logic [COL_BITS-1:0]  cmd_col;

	logic [ADDR_BITS:0]   sb_q [$];                     // accepted requests, {op, addr}
	logic [NUM_BANKS-1:0] model_open = '0;              // open-row model from observed commands
	logic [ROW_BITS-1:0]  model_row [NUM_BANKS];
	logic [ROW_BITS-1:0]  row_set [4] = '{8'h03, 8'h11, 8'h5a, 8'h11}; // few rows, many conflicts
	logic [31:0]          lcg_state = 32'h405c77c7;
	string                cur_test = "none";
	int                   checks = 0;
	int                   errors = 0;
	int                   test_checks = 0;
	int                   test_errors = 0;
	int                   tests = 0;
	int                   cycles = 0;      // cycles out of reset
	int                   ref_count = 0;
	int                   full_cycles = 0; // cycles with full high
	int                   bank0_cmds = 0;

	dram_sched #(
		.QUEUE_DEPTH(QUEUE_DEPTH), .T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS),
		.T_CCD(T_CCD), .T_RRD(T_RRD), .T_REFI(T_REFI), .T_RFC(T_RFC)
	) i_dut (
		.clk, .rst_n, .req_valid, .req_op, .req_addr, .full,
		.cmd_valid, .cmd_op, .cmd_bank, .cmd_row, .cmd_col
	);

	bind dram_sched dram_sched_asserts #(
		.T_RCD(T_RCD), .T_RP(T_RP), .T_RAS(T_RAS), .T_CCD(T_CCD), .T_RRD(T_RRD), .T_RFC(T_RFC)
	) i_asserts (.clk, .rst_n, .cmd_valid, .cmd_op, .cmd_bank);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// row | bank | col, msb first
	function automatic logic [ADDR_BITS-1:0] make_addr(input logic [ROW_BITS-1:0] row,
		input logic [BANK_BITS-1:0] bank, input logic [COL_BITS-1:0] col);
		return {row, bank, col};
	endfunction

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (expected == actual) else begin
			$display("ERR %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("%s: %s", cur_test, msg);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic finish_test();
		tests++;
		$display("%s: %0d checks, %0d errors", cur_test, checks - test_checks,
			errors - test_errors);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1; // inputs move just after the edge
	endtask

	// strobe for one cycle, only once there is room
	task automatic send_request(input req_op_t op, input logic [ADDR_BITS-1:0] addr);
		while (full) next_cycle();
		req_valid = 1'b1;
		req_op    = op;
		req_addr  = addr;
		next_cycle();
		req_valid = 1'b0;
	endtask

	task automatic send_random();
		logic [31:0] r;
		r = lcg_next();
		send_request(req_op_t'(r[31]), make_addr(row_set[r[17:16]], r[21:20], r[29:24]));
	endtask

	task automatic wait_drain();
		while (sb_q.size() != 0) next_cycle();
	endtask

	// row policy against the model, column commands against the scoreboard
	task automatic check_command();
		logic [ADDR_BITS:0] hd;
		cmd_op_t            exp_op;
		hd = (sb_q.size() != 0) ? sb_q[0] : '0;
		exp_op = hd[ADDR_BITS] ? CMD_WR : CMD_RD;
		case (cmd_op)
			CMD_ACT: begin
				check_true(!model_open[cmd_bank], "ACT issued to a bank that is already open");
				check_true(sb_q.size() != 0, "ACT issued with no request pending");
				compare_value("act bank", 32'(hd[BANK_LSB +: BANK_BITS]), 32'(cmd_bank));
				compare_value("act row", 32'(hd[ROW_LSB +: ROW_BITS]), 32'(cmd_row));
				model_open[cmd_bank] = 1'b1;
				model_row[cmd_bank]  = cmd_row;
			end
			CMD_PRE: begin
				check_true(model_open[cmd_bank], "PRE issued to a bank that is closed");
				model_open[cmd_bank] = 1'b0;
			end
			CMD_RD, CMD_WR: begin
				check_true(model_open[cmd_bank] && model_row[cmd_bank] == cmd_row,
					"column command issued to a bank without that row open");
				check_true(sb_q.size() != 0, "column command issued with no request pending");
				compare_value("op", 32'(exp_op), 32'(cmd_op));
				compare_value("bank", 32'(hd[BANK_LSB +: BANK_BITS]), 32'(cmd_bank));
				compare_value("row", 32'(hd[ROW_LSB +: ROW_BITS]), 32'(cmd_row));
				compare_value("col", 32'(hd[COL_BITS-1:0]), 32'(cmd_col));
				if (sb_q.size() != 0) void'(sb_q.pop_front());
			end
			CMD_REF: begin
				ref_count++;
				model_open = '0;
			end
			default: check_true(1'b0, "unknown command code on cmd_op");
		endcase
	endtask

	// mid-cycle monitor, inputs and registered outputs are both settled here
	always @(negedge clk) begin
		if (rst_n) begin
			cycles++;
			if (full) full_cycles++;
			if (cmd_valid) begin
				if (cmd_bank == '0) bank0_cmds++;
				check_command(); // before the push, a new request is not at the head yet
			end
			if (req_valid && !full) sb_q.push_back({req_op, req_addr});
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		int          snap;
		int          full_snap;
		int          all_errors;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_op    = REQ_READ;
		req_addr  = '0;

		start_test("reset_state");
		repeat (3) begin
			next_cycle(); // just after each edge held in reset
			compare_value("cmd_valid", 32'd0, 32'(cmd_valid));
			compare_value("full", 32'd0, 32'(full));
		end
		rst_n = 1'b1;
		@(negedge clk); // first cycle out of reset
		compare_value("cmd_valid", 32'd0, 32'(cmd_valid));
		compare_value("full", 32'd0, 32'(full));
		next_cycle();
		finish_test();

		start_test("in_order");
		repeat (N_RAND) begin
			r = lcg_next();
			repeat (r[13:12]) next_cycle(); // idle gap of 0 to 3 cycles
			send_random();
		end
		wait_drain();
		finish_test();

		// open a row in bank 0, then conflict with it and burst while it precharges
		start_test("full_flag");
		send_request(REQ_WRITE, make_addr(8'h22, 2'd0, 6'd1));
		wait_drain();
		snap      = bank0_cmds;
		full_snap = full_cycles;
		send_request(REQ_READ, make_addr(8'h44, 2'd0, 6'd2));
		while (bank0_cmds == snap) next_cycle();
		repeat (QUEUE_DEPTH) send_random();
		wait_drain();
		check_true(full_cycles > full_snap, "full never rose during the back-to-back burst");
		finish_test();

		start_test("refresh");
		while (cycles < REF_WAIT) next_cycle();
		check_true(ref_count > 0, "no REF was issued during the run");
		finish_test();

		all_errors = errors + i_dut.i_asserts.fail_count;
		$display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, i_dut.i_asserts.fail_count);
		if (all_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: dram_sched.f
rtl/dram_sched_pkg.sv
rtl/request_queue.sv
rtl/bank_tracker.sv
rtl/refresh_timer.sv
rtl/command_sequencer.sv
rtl/dram_sched.sv
test/dram_sched_asserts.sv
test/dram_sched_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the dram_sched testbench with verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module dram_sched_tb \
	-Mdir obj_dir -f dram_sched.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

# keep running past assertion errors so the testbench prints its own summary
./obj_dir/Vdram_sched_tb +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1
